/* include/mipsCore_settings.svh */
// ==========================================================
// core sizing; the field slicing in decode assumes the
// 32-bit MIPS encoding, so DATA_W stays at 32
// ==========================================================
`ifndef MIPSCORE_SETTINGS_SVH
`define MIPSCORE_SETTINGS_SVH

// datapath and register file
`define DATA_W     32
`define REG_COUNT  32
// first fetch address and instruction ROM size in words
`define RESET_PC   32'h0000_0000
`define IMEM_DEPTH 64

`endif

/* logic/isaPkg.sv */
// ==========================================================
// MIPS subset encodings: R-type add/sub/and/or/slt, addi,
// lw, sw, beq and j only; anything else decodes as a nop
// ==========================================================
`include "mipsCore_settings.svh"

package isaPkg;

	typedef logic [`DATA_W-1:0] instrT;
	typedef logic [5:0] opcodeT;

	// primary opcodes, instr[31:26]
	localparam opcodeT opRtype = 6'b000000;
	localparam opcodeT opJ     = 6'b000010;
	localparam opcodeT opBeq   = 6'b000100;
	localparam opcodeT opAddi  = 6'b001000;
	localparam opcodeT opLw    = 6'b100011;
	localparam opcodeT opSw    = 6'b101011;

	// funct field of R-type, instr[5:0]
	localparam opcodeT fnAdd = 6'b100000;
	localparam opcodeT fnSub = 6'b100010;
	localparam opcodeT fnAnd = 6'b100100;
	localparam opcodeT fnOr  = 6'b100101;
	localparam opcodeT fnSlt = 6'b101010;

	// bit 2 set means the second operand is negated
	typedef enum logic [2:0] {
		aluAnd = 3'b000,
		aluOr  = 3'b001,
		aluAdd = 3'b010,
		aluSub = 3'b110,
		aluSlt = 3'b111
	} aluOpE;

	// all-zero word is a nop with every write enable low
	typedef struct packed {
		logic  regWrite;
		logic  memToReg;
		logic  memWrite;
		logic  aluSrc;
		logic  branch;
		logic  jump;
		aluOpE aluOp;
		logic  regDst;
	} ctrlT;

endpackage

/* logic/pipePkg.sv */
// ==========================================================
// pipeline register payloads and the data memory request;
// an all-zero payload is always a harmless bubble
// ==========================================================
`include "mipsCore_settings.svh"

package pipePkg;
	import isaPkg::*;

	localparam int RegIdxW = $clog2(`REG_COUNT);

	typedef logic [RegIdxW-1:0] regIdxT;
	typedef logic [`DATA_W-1:0] wordT;

	// fetch to decode
	typedef struct packed {
		logic  valid;
		instrT instr;
		wordT  pcPlus4;
	} ifIdT;

	// decode to execute
	// opA and opB are register file values before EX forwarding
	typedef struct packed {
		logic   valid;
		ctrlT   ctrl;
		regIdxT rs;
		regIdxT rt;
		regIdxT dst;
		wordT   opA;
		wordT   opB;
		wordT   imm;
	} idExT;

	// execute to memory
	typedef struct packed {
		logic   valid;
		ctrlT   ctrl;
		regIdxT dst;
		wordT   aluResult;
		wordT   storeData;
	} exMemT;

	// memory to write-back, only the write-back controls survive
	typedef struct packed {
		logic   valid;
		logic   regWrite;
		logic   memToReg;
		regIdxT dst;
		wordT   aluResult;
		wordT   loadData;
	} memWbT;

	// word access only, write lands on the next rising edge
	typedef struct packed {
		logic we;
		wordT addr;
		wordT wdata;
	} dmemReqT;

	typedef enum logic [1:0] {
		fwdNone = 2'b00,
		fwdWb   = 2'b01,
		fwdMem  = 2'b10
	} fwdSelE;

endpackage

/* logic/stageReg.sv */
// ==========================================================
// generic pipeline register; flush beats stall, and both
// reset and flush load an all-zero bubble
// ==========================================================
`timescale 1ns/1ps

module stageReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    stall,
	input  logic    flush,
	input  payloadT d,
	output payloadT q
);

	always_ff @(posedge clk) begin
		// zero payload means valid low and every enable low
		if (!rstN || flush) begin
			q <= '0;
		end else if (!stall) begin
			q <= d;
		end
		// stall without flush keeps the current instruction
	end

endmodule

/* logic/decodeStage.sv */
// ==========================================================
// decode with register file; write-back data bypasses to
// same-cycle reads, beq and j resolve here
// ==========================================================
`timescale 1ns/1ps
`include "mipsCore_settings.svh"

module decodeStage
	import isaPkg::*;
	import pipePkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  ifIdT   ifId,
	input  logic   wbWrite,
	input  regIdxT wbReg,
	input  wordT   wbData,
	input  wordT   memResult,
	input  logic   fwdA,
	input  logic   fwdB,
	output idExT   idEx,
	output wordT   pcTarget,
	output logic   redirect,
	output regIdxT rs,
	output regIdxT rt,
	output logic   isBranch
);

	wordT   regs [`REG_COUNT];
	instrT  instr;
	opcodeT opcode;
	opcodeT funct;
	regIdxT rd;
	ctrlT   ctrl;
	wordT   rdA;
	wordT   rdB;
	wordT   cmpA;
	wordT   cmpB;
	wordT   signImm;
	wordT   branchTarget;
	wordT   jumpTarget;

	assign instr  = ifId.instr;
	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	// register file, written on the same edge as the rest of the core
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite && wbReg != '0) begin
			regs[wbReg] <= wbData;
		end
	end

	// r0 reads zero, otherwise a same-cycle write wins over the array
	assign rdA = (rs == '0) ? '0 : (wbWrite && wbReg == rs) ? wbData : regs[rs];
	assign rdB = (rt == '0) ? '0 : (wbWrite && wbReg == rt) ? wbData : regs[rt];

	always_comb begin
		ctrl = '0;
		case (opcode)
			opRtype: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = 1'b1;
				case (funct)
					fnAdd:   ctrl.aluOp = aluAdd;
					fnSub:   ctrl.aluOp = aluSub;
					fnAnd:   ctrl.aluOp = aluAnd;
					fnOr:    ctrl.aluOp = aluOr;
					fnSlt:   ctrl.aluOp = aluSlt;
					// unsupported funct, incl. sll nop, writes nothing
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			opBeq: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp  = aluSub;
			end
			opJ: begin
				ctrl.jump = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
		// bubble in IF/ID must not act
		if (!ifId.valid) begin
			ctrl = '0;
		end
	end

	assign signImm      = {{(`DATA_W - 16){instr[15]}}, instr[15:0]};
	assign branchTarget = ifId.pcPlus4 + (signImm << 2);
	assign jumpTarget   = {ifId.pcPlus4[31:28], instr[25:0], 2'b00};

	// comparator sees the EX/MEM result one cycle before write-back
	assign cmpA = fwdA ? memResult : rdA;
	assign cmpB = fwdB ? memResult : rdB;

	assign isBranch = ctrl.branch;
	assign redirect = ctrl.jump || (ctrl.branch && cmpA == cmpB);
	assign pcTarget = ctrl.jump ? jumpTarget : branchTarget;

	always_comb begin
		idEx.valid = ifId.valid;
		idEx.ctrl  = ctrl;
		idEx.rs    = rs;
		idEx.rt    = rt;
		// R-type writes rd, addi and lw write rt
		idEx.dst   = ctrl.regDst ? rd : rt;
		idEx.opA   = rdA;
		idEx.opB   = rdB;
		idEx.imm   = signImm;
	end

endmodule

/* logic/executeStage.sv */
// ==========================================================
// execute: forwarding muxes and ALU; slt is signed and the
// EX/MEM forward is assumed never to be load data
// ==========================================================
`timescale 1ns/1ps

module executeStage
	import isaPkg::*;
	import pipePkg::*;
(
	input  idExT   idEx,
	input  fwdSelE fwdA,
	input  fwdSelE fwdB,
	input  wordT   memResult,
	input  wordT   wbResult,
	output exMemT  exMem
);

	wordT srcA;
	wordT regB;
	wordT srcB;
	wordT aluOut;

	// newer producer sits in memory, older one in write-back
	function automatic wordT pickOperand(fwdSelE sel, wordT regVal, wordT memVal,
			wordT wbVal);
		case (sel)
			fwdMem:  return memVal;
			fwdWb:   return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign srcA = pickOperand(fwdA, idEx.opA, memResult, wbResult);
	assign regB = pickOperand(fwdB, idEx.opB, memResult, wbResult);
	// immediate for addi, lw and sw address
	assign srcB = idEx.ctrl.aluSrc ? idEx.imm : regB;

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluAnd:  aluOut = srcA & srcB;
			aluOr:   aluOut = srcA | srcB;
			aluAdd:  aluOut = srcA + srcB;
			aluSub:  aluOut = srcA - srcB;
			aluSlt:  aluOut = wordT'($signed(srcA) < $signed(srcB));
			default: aluOut = srcA + srcB;
		endcase
	end

	always_comb begin
		exMem.valid     = idEx.valid;
		exMem.ctrl      = idEx.ctrl;
		exMem.dst       = idEx.dst;
		exMem.aluResult = aluOut;
		// sw stores the forwarded rt, not the immediate
		exMem.storeData = regB;
	end

endmodule

/* logic/hazardUnit.sv */
// ==========================================================
// forwarding selects and stall decision; register 0 never
// forwards, rs/rt of a j may cause a harmless extra stall
// ==========================================================
`timescale 1ns/1ps

module hazardUnit
	import pipePkg::*;
(
	input  regIdxT rs,
	input  regIdxT rt,
	input  logic   isBranch,
	input  idExT   idEx,
	input  exMemT  exMem,
	input  memWbT  memWb,
	output logic   fwdDecA,
	output logic   fwdDecB,
	output fwdSelE fwdExA,
	output fwdSelE fwdExB,
	output logic   stallFront,
	output logic   bubbleEx
);

	logic exWrites;
	logic loadInEx;
	logic loadInMem;

	// true when a writing stage targets the given source register
	function automatic logic hits(logic wr, regIdxT dst, regIdxT src);
		return wr && dst != '0 && dst == src;
	endfunction

	function automatic fwdSelE exSource(regIdxT src, exMemT mem, memWbT wb);
		if (hits(mem.ctrl.regWrite, mem.dst, src)) begin
			return fwdMem;
		end
		if (hits(wb.regWrite, wb.dst, src)) begin
			return fwdWb;
		end
		return fwdNone;
	endfunction

	assign fwdExA = exSource(idEx.rs, exMem, memWb);
	assign fwdExB = exSource(idEx.rt, exMem, memWb);

	// decode comparator takes ALU results only, loads stall instead
	assign fwdDecA = hits(exMem.ctrl.regWrite && !exMem.ctrl.memToReg, exMem.dst, rs);
	assign fwdDecB = hits(exMem.ctrl.regWrite && !exMem.ctrl.memToReg, exMem.dst, rt);

	assign exWrites = hits(idEx.ctrl.regWrite, idEx.dst, rs)
		|| hits(idEx.ctrl.regWrite, idEx.dst, rt);
	assign loadInEx  = idEx.ctrl.memToReg && exWrites;
	assign loadInMem = exMem.ctrl.memToReg
		&& (hits(exMem.ctrl.regWrite, exMem.dst, rs)
		|| hits(exMem.ctrl.regWrite, exMem.dst, rt));

	// load-use, or a beq whose operand is not yet visible in decode
	assign stallFront = loadInEx || (isBranch && (exWrites || loadInMem));
	assign bubbleEx   = stallFront;

endmodule

/* logic/mipsCore.sv */
// ==========================================================
// five-stage MIPS core; instruction and data memories are
// external and answer combinationally, no handshake
// ==========================================================
`timescale 1ns/1ps
`include "mipsCore_settings.svh"

module mipsCore
	import pipePkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	output wordT    imemAddr,
	input  wordT    imemData,
	output dmemReqT dmemReq,
	input  wordT    dmemRdata
);

	wordT   pc;
	wordT   pcPlus4;
	wordT   pcNext;
	wordT   pcTarget;
	wordT   wbResult;
	ifIdT   ifIdD;
	ifIdT   ifIdQ;
	idExT   idExD;
	idExT   idExQ;
	exMemT  exMemD;
	exMemT  exMemQ;
	memWbT  memWbD;
	memWbT  memWbQ;
	regIdxT rs;
	regIdxT rt;
	logic   redirect;
	logic   isBranch;
	logic   fwdDecA;
	logic   fwdDecB;
	fwdSelE fwdExA;
	fwdSelE fwdExB;
	logic   stallFront;
	logic   bubbleEx;
	logic   flushIfId;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else if (!stallFront) begin
			pc <= pcNext;
		end
	end

	assign pcPlus4  = pc + 32'd4;
	assign pcNext   = redirect ? pcTarget : pcPlus4;
	assign imemAddr = pc;

	// a stalled branch has stale operands, so its redirect waits
	assign flushIfId = redirect && !stallFront;

	assign ifIdD = '{valid: 1'b1, instr: imemData, pcPlus4: pcPlus4};

	stageReg #(.payloadT(ifIdT)) uIfId (
		.clk(clk), .rstN(rstN), .stall(stallFront), .flush(flushIfId),
		.d(ifIdD), .q(ifIdQ)
	);

	decodeStage uDecode (
		.clk(clk), .rstN(rstN), .ifId(ifIdQ),
		.wbWrite(memWbQ.regWrite), .wbReg(memWbQ.dst), .wbData(wbResult),
		.memResult(exMemQ.aluResult), .fwdA(fwdDecA), .fwdB(fwdDecB),
		.idEx(idExD), .pcTarget(pcTarget), .redirect(redirect),
		.rs(rs), .rt(rt), .isBranch(isBranch)
	);

	hazardUnit uHazard (
		.rs(rs), .rt(rt), .isBranch(isBranch),
		.idEx(idExQ), .exMem(exMemQ), .memWb(memWbQ),
		.fwdDecA(fwdDecA), .fwdDecB(fwdDecB), .fwdExA(fwdExA), .fwdExB(fwdExB),
		.stallFront(stallFront), .bubbleEx(bubbleEx)
	);

	// ID/EX never holds, a stall only turns it into a bubble
	stageReg #(.payloadT(idExT)) uIdEx (
		.clk(clk), .rstN(rstN), .stall(1'b0), .flush(bubbleEx),
		.d(idExD), .q(idExQ)
	);

	executeStage uExecute (
		.idEx(idExQ), .fwdA(fwdExA), .fwdB(fwdExB),
		.memResult(exMemQ.aluResult), .wbResult(wbResult), .exMem(exMemD)
	);

	stageReg #(.payloadT(exMemT)) uExMem (
		.clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0),
		.d(exMemD), .q(exMemQ)
	);

	// memory stage drives the data port straight from EX/MEM
	assign dmemReq = '{we: exMemQ.ctrl.memWrite, addr: exMemQ.aluResult,
		wdata: exMemQ.storeData};

	assign memWbD = '{valid: exMemQ.valid, regWrite: exMemQ.ctrl.regWrite,
		memToReg: exMemQ.ctrl.memToReg, dst: exMemQ.dst,
		aluResult: exMemQ.aluResult, loadData: dmemRdata};

	stageReg #(.payloadT(memWbT)) uMemWb (
		.clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0),
		.d(memWbD), .q(memWbQ)
	);

	// write-back select, also the older forwarding source
	assign wbResult = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluResult;

endmodule

/* dv/mipsCore_assertions.sv */
// ==========================================================
// bound into mipsCore; reads the expected store table and
// bumps the failure count held in the coreTb top
// ==========================================================
`timescale 1ns/1ps
`include "mipsCore_settings.svh"

module mipsCoreAssertions
	import pipePkg::*;
(
	input logic    clk,
	input logic    rstN,
	input wordT    imemAddr,
	input dmemReqT dmemReq
);

	logic [5:0] slot;
	logic       known;

	// word slot inside the 256-byte data window
	assign slot  = dmemReq.addr[7:2];
	assign known = dmemReq.addr[31:8] == '0 && coreTb.expKnown[slot];

	// registers are cleared from the first reset edge on
	quietInReset: assert property (@(posedge clk) !rstN && $past(!rstN) |-> !dmemReq.we)
		else begin
			coreTb.assertFails++;
			$error("CHECK FAILED at %0t: store enable high during reset", $time);
		end

	// first cycle out of reset fetches the reset vector, no store yet
	firstFetch: assert property (@(posedge clk)
			$rose(rstN) |-> imemAddr == `RESET_PC && !dmemReq.we)
		else begin
			coreTb.assertFails++;
			$error("CHECK FAILED at %0t: first fetch from %h", $time, imemAddr);
		end

	// poison and unlisted addresses are never written
	noStrayStore: assert property (@(posedge clk) disable iff (!rstN)
			dmemReq.we |-> known)
		else begin
			coreTb.assertFails++;
			$error("CHECK FAILED at %0t: store to address %h", $time, dmemReq.addr);
		end

	storeValue: assert property (@(posedge clk) disable iff (!rstN)
			dmemReq.we && known |-> dmemReq.wdata == coreTb.expData[slot])
		else begin
			coreTb.assertFails++;
			$error("CHECK FAILED at %0t: address %h got %h, expected %h", $time,
				dmemReq.addr, dmemReq.wdata, coreTb.expData[slot]);
		end

endmodule

/* dv/coreTb.sv */
// ==========================================================
// hand-encoded MIPS program; a store to 0x80 + 4*id closes
// test id; data memory is a 64-word window at address 0
// ==========================================================
`timescale 1ns/1ps
`include "mipsCore_settings.svh"

module coreTb
	import pipePkg::*;
();

	localparam int imemAw   = $clog2(`IMEM_DEPTH);
	localparam int lastTest = 6;
	// MIPS opcode and funct encodings
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opAddi  = 6'h08;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;
	localparam logic [5:0] fnAdd   = 6'h20;
	localparam logic [5:0] fnSub   = 6'h22;
	localparam logic [5:0] fnAnd   = 6'h24;
	localparam logic [5:0] fnOr    = 6'h25;
	localparam logic [5:0] fnSlt   = 6'h2a;

	logic    clk;
	logic    rstN;
	wordT    imemAddr;
	wordT    imemData;
	dmemReqT dmemReq;
	wordT    dmemRdata;
	wordT    imem [`IMEM_DEPTH];
	wordT    dmem [64];
	logic    seen [64];
	wordT    expData [64];
	logic    expKnown [64];
	int      assertFails = 0;
	int      failsAtLast = 0;
	int      emitIdx = 0;
	int      seed;

	mipsCore u_dut (
		.clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
		.dmemReq(dmemReq), .dmemRdata(dmemRdata)
	);

	bind mipsCore mipsCoreAssertions uChecks (
		.clk(clk), .rstN(rstN), .imemAddr(imemAddr), .dmemReq(dmemReq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// both memories answer in the same cycle
	assign imemData  = imem[imemAddr[imemAw+1:2]];
	assign dmemRdata = dmem[dmemReq.addr[7:2]];

	initial begin
		for (int i = 0; i < 64; i++) begin
			dmem[i[5:0]] = 32'hdead_0000 | wordT'(i << 2);
			seen[i[5:0]] = 1'b0;
		end
	end

	always @(posedge clk) begin
		if (rstN && dmemReq.we) begin
			dmem[dmemReq.addr[7:2]] <= dmemReq.wdata;
			seen[dmemReq.addr[7:2]] <= 1'b1;
		end
	end

	function automatic wordT rType(logic [5:0] fn, int rd, int rs, int rt);
		return {opRtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic wordT iType(logic [5:0] op, int rt, int rs, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	// target is a word index
	function automatic wordT jType(int target);
		return {opJ, target[25:0]};
	endfunction

	function automatic wordT markerAddr(int id);
		return 32'h80 + wordT'(id * 4);
	endfunction

	function automatic string testLabel(int id);
		case (id)
			1:       return "reset";
			2:       return "forwarding";
			3:       return "load-use";
			4:       return "branches";
			5:       return "jump";
			default: return "register zero";
		endcase
	endfunction

	task automatic emit(wordT instr);
		imem[emitIdx[imemAw-1:0]] = instr;
		emitIdx++;
	endtask

	task automatic expectStore(wordT addr, wordT value);
		expData[addr[7:2]]  = value;
		expKnown[addr[7:2]] = 1'b1;
	endtask

	// r8 carries the test id to its marker word
	task automatic closeTest(int id);
		emit(iType(opAddi, 8, 0, id));
		emit(iType(opSw, 8, 0, markerAddr(id)));
		expectStore(markerAddr(id), wordT'(id));
	endtask

	task automatic reportTest(int id);
		$display("test %0d %s finished at %0t, %0d failed checks", id, testLabel(id), $time,
			assertFails - failsAtLast);
		failsAtLast = assertFails;
	endtask

	initial begin
		wordT r1, r2, r3, r4, r5, r6, r7;
		int c1, c2, nextTest, missing;
		rstN = 1'b0;
		seed = 53;
		// small positive operands
		// c2 nonzero keeps the second beq not taken
		c1 = ($random(seed) & 32'h7f) + 1;
		c2 = ($random(seed) & 32'h7f) + 1;
		// unused words jump to themselves
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			imem[i[imemAw-1:0]] = jType(i);
		end
		for (int i = 0; i < 64; i++) begin
			expKnown[i[5:0]] = 1'b0;
			expData[i[5:0]]  = '0;
		end
		// sequential register values of the program
		r1 = c1;
		r2 = r1 + wordT'(c2);
		r3 = r2 + r1;
		r4 = r3 - r1;
		r5 = r4 & r3;
		r6 = r5 | r2;
		r7 = ($signed(r1) < $signed(r6)) ? 32'd1 : 32'd0;
		// forwarding chain
		emit(iType(opAddi, 1, 0, c1));
		emit(iType(opAddi, 2, 1, c2));
		emit(rType(fnAdd, 3, 2, 1));
		emit(rType(fnSub, 4, 3, 1));
		emit(rType(fnAnd, 5, 4, 3));
		emit(rType(fnOr, 6, 5, 2));
		emit(rType(fnSlt, 7, 1, 6));
		emit(iType(opSw, 3, 0, 0));
		emit(iType(opSw, 4, 0, 4));
		emit(iType(opSw, 5, 0, 8));
		emit(iType(opSw, 6, 0, 12));
		emit(iType(opSw, 7, 0, 16));
		expectStore(0, r3);
		expectStore(4, r4);
		expectStore(8, r5);
		expectStore(12, r6);
		expectStore(16, r7);
		closeTest(2);
		// load then dependent add
		emit(iType(opLw, 9, 0, 4));
		emit(rType(fnAdd, 10, 9, 1));
		emit(iType(opSw, 10, 0, 20));
		expectStore(20, r4 + r1);
		closeTest(3);
		// taken on a result still in execute, then not taken, then taken on a load
		emit(iType(opAddi, 11, 0, c1));
		emit(iType(opBeq, 1, 11, 1));
		emit(iType(opSw, 1, 0, 'hf0));
		emit(iType(opBeq, 1, 2, 1));
		emit(iType(opSw, 2, 0, 24));
		emit(iType(opLw, 12, 0, 0));
		emit(iType(opBeq, 3, 12, 1));
		emit(iType(opSw, 1, 0, 'hf4));
		expectStore(24, r2);
		closeTest(4);
		// jump over one poison store
		emit(jType(emitIdx + 2));
		emit(iType(opSw, 1, 0, 'hf8));
		emit(iType(opSw, 1, 0, 28));
		expectStore(28, r1);
		closeTest(5);
		emit(iType(opAddi, 0, 0, c2));
		emit(iType(opSw, 0, 0, 32));
		expectStore(32, '0);
		closeTest(6);

		repeat (4) @(posedge clk);
		#1 rstN = 1'b1;
		@(posedge clk);
		#1;
		reportTest(1);
		nextTest = 2;
		// marker store is stable on the bus at the falling edge
		while (nextTest <= lastTest) begin
			@(negedge clk);
			if (dmemReq.we && dmemReq.addr == markerAddr(nextTest)) begin
				reportTest(nextTest);
				nextTest++;
			end
		end
		// let the last marker land
		@(posedge clk);
		#1;
		missing = 0;
		for (int i = 0; i < 64; i++) begin
			if (expKnown[i[5:0]] && !seen[i[5:0]]) begin
				$display("store to address %h never reached data memory", i * 4);
				missing++;
			end
		end
		$display("%0d tests finished, %0d failed checks, %0d missing stores", lastTest,
			assertFails, missing);
		if (assertFails == 0 && missing == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// the whole program takes well under three passes over the ROM
	initial begin
		repeat (3 * `IMEM_DEPTH + 50) @(posedge clk);
		$display("watchdog expired at %0t, the program never reached its last marker", $time);
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* sim.f */
+incdir+include
logic/isaPkg.sv
logic/pipePkg.sv
logic/stageReg.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/hazardUnit.sv
logic/mipsCore.sv
dv/mipsCore_assertions.sv
dv/coreTb.sv

/* Makefile */
# Verilator build, run and lint for the MIPS core testbench
TOP := coreTb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

obj_dir/V$(TOP): sim.f $(wildcard include/*.svh logic/*.sv dv/*.sv)
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
